/* design/fxp_defines.svh */
`ifndef FXP_DEFINES_SVH
`define FXP_DEFINES_SVH

// sample, gain and result width
`define FXP_WIDTH 32

// fraction bits of the fixed-point format
`define FXP_FRAC 16

// configuration register map, one address bit
`define FXP_ADDR_GAIN 1'b0
`define FXP_ADDR_MODE 1'b1

// unity gain, 1.0 in the fixed-point format
`define FXP_GAIN_RESET (32'd1 << `FXP_FRAC)

`endif

/* design/fxp_pkg.sv */
`default_nettype none

`include "fxp_defines.svh"

package fxp_pkg;

  // ============================================================
  // configuration word layouts
  // ============================================================

  // mode register, only the lowest bit is defined
  typedef struct packed {
    logic [`FXP_WIDTH-2:0] reserved;
    logic                  signed_en;
  } mode_t;

  // write data seen either as a gain or as a mode word
  typedef union packed {
    logic [`FXP_WIDTH-1:0] gain;
    mode_t                 mode;
  } cfg_wdata_u;

  // ============================================================
  // configuration handed to the datapath
  // ============================================================

  typedef struct packed {
    logic [`FXP_WIDTH-1:0] gain;
    logic                  signed_en;
  } cfg_t;

endpackage

`default_nettype wire

/* design/fxp_gain_regs.sv */
`default_nettype none

`include "fxp_defines.svh"

module fxp_gain_regs (
  input  logic               clk,
  input  logic               reset,
  input  logic               cfg_wr,
  input  logic               cfg_addr,
  input  fxp_pkg::cfg_wdata_u cfg_wdata,
  output fxp_pkg::cfg_t      cfg
);

  logic gain_wr;
  logic mode_wr;

  // address decode of the write strobe
  assign gain_wr = cfg_wr && (cfg_addr == `FXP_ADDR_GAIN);
  assign mode_wr = cfg_wr && (cfg_addr == `FXP_ADDR_MODE);

  // ============================================================
  // register storage
  // ============================================================

  // gain register, comes up at 1.0
  always_ff @(posedge clk) begin
    if (reset) begin
      cfg.gain <= `FXP_GAIN_RESET;
    end else if (gain_wr) begin
      cfg.gain <= cfg_wdata.gain;
    end
  end

  // mode register, comes up signed
  always_ff @(posedge clk) begin
    if (reset) begin
      cfg.signed_en <= 1'b1;
    end else if (mode_wr) begin
      cfg.signed_en <= cfg_wdata.mode.signed_en;
    end
  end

  // ============================================================
  // checks
  // ============================================================

  // a write with an unknown address would update neither register
  addr_known_a : assert property (
    @(posedge clk) disable iff (reset)
    cfg_wr |-> !$isunknown(cfg_addr)
  ) else $error("cfg_addr unknown during a configuration write");

endmodule

`default_nettype wire

/* design/fxp_mult_ctrl.sv */
`default_nettype none

`include "fxp_defines.svh"

module fxp_mult_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic recv_val,
  input  logic send_rdy,
  output logic recv_rdy,
  output logic send_val,
  output logic in_wait,
  output logic do_add,
  output logic do_carry
);

  localparam int CNT_W = $clog2(`FXP_WIDTH);

  typedef enum logic [1:0] {
    s_idle,
    s_calc,
    s_done
  } state_t;

  state_t           state;
  state_t           next_state;
  logic [CNT_W-1:0] count;
  logic             last_iter;

  // one iteration per gain bit
  assign last_iter = (count == CNT_W'(`FXP_WIDTH - 1));

  // ============================================================
  // state machine
  // ============================================================

  always_comb begin
    next_state = state;
    case (state)
      s_idle: if (recv_val) next_state = s_calc;
      s_calc: if (last_iter) next_state = s_done;
      s_done: if (send_rdy) next_state = s_idle;
      default: next_state = s_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= s_idle;
    end else begin
      state <= next_state;
    end
  end

  // iteration counter, cleared while the result waits
  always_ff @(posedge clk) begin
    if (reset || state == s_done) begin
      count <= '0;
    end else if (state == s_calc) begin
      count <= count + 1'b1;
    end
  end

  // handshake and datapath controls straight from state
  assign in_wait  = (state == s_idle);
  assign recv_rdy = (state == s_idle);
  assign do_add   = (state == s_calc);
  assign do_carry = (state == s_calc) && last_iter;
  assign send_val = (state == s_done);

  // ============================================================
  // checks
  // ============================================================

  hs_excl_a : assert property (
    @(posedge clk) disable iff (reset)
    !(recv_rdy && send_val)
  ) else $error("recv_rdy and send_val high together");

  // sign correction on the last of FXP_WIDTH adds after the load
  carry_last_a : assert property (
    @(posedge clk) disable iff (reset)
    do_carry |-> do_add && $past(in_wait, `FXP_WIDTH)
  ) else $error("do_carry outside the last calculate cycle");

endmodule

`default_nettype wire

/* design/fxp_mult_dpath.sv */
`default_nettype none

`include "fxp_defines.svh"

module fxp_mult_dpath (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  in_wait,
  input  logic                  do_add,
  input  logic                  do_carry,
  input  logic [`FXP_WIDTH-1:0] sample,
  input  fxp_pkg::cfg_t         cfg,
  output logic [`FXP_WIDTH-1:0] result
);

  // product kept to width plus fraction, upper bits drop out anyway
  localparam int ACC_W = `FXP_WIDTH + `FXP_FRAC;

  logic [ACC_W-1:0]      sample_ext;
  logic [ACC_W-1:0]      acc;
  logic [ACC_W-1:0]      a_shift;
  logic [ACC_W-1:0]      a_const;
  logic [`FXP_WIDTH-1:0] b_shift;
  logic                  sign_lat;
  logic [ACC_W-1:0]      a_top;
  logic [ACC_W-1:0]      neg_term;
  logic [ACC_W-1:0]      addend;

  // sign extend only in signed mode
  assign sample_ext = {{`FXP_FRAC{cfg.signed_en & sample[`FXP_WIDTH-1]}}, sample};

  // ============================================================
  // operand registers
  // ============================================================

  // reloaded every idle cycle, the accepting edge is the last load
  always_ff @(posedge clk) begin
    if (in_wait) begin
      a_shift  <= sample_ext;
      a_const  <= sample_ext;
      b_shift  <= cfg.gain;
      sign_lat <= cfg.signed_en;
    end else if (do_add) begin
      a_shift <= a_shift << 1;
      b_shift <= b_shift >> 1;
    end
  end

  // ============================================================
  // accumulate
  // ============================================================

  // gain sign bit weighs -2^(width-1) in signed mode
  assign a_top    = a_const << (`FXP_WIDTH - 1);
  assign neg_term = '0 - a_top;

  always_comb begin
    if (do_carry && sign_lat) begin
      addend = neg_term;
    end else begin
      addend = a_shift;
    end
  end

  // cleared in idle, frozen in done
  always_ff @(posedge clk) begin
    if (reset || in_wait) begin
      acc <= '0;
    end else if (do_add && b_shift[0]) begin
      acc <= acc + addend;
    end
  end

  // drop the fraction bits, floor by truncation
  assign result = acc[ACC_W-1:`FXP_FRAC];

endmodule

`default_nettype wire

/* design/fxp_gain_stage.sv */
`default_nettype none

`include "fxp_defines.svh"

module fxp_gain_stage (
  input  logic                  clk,
  input  logic                  reset,

  // configuration writes
  input  logic                  cfg_wr,
  input  logic                  cfg_addr,
  input  fxp_pkg::cfg_wdata_u   cfg_wdata,

  // sample stream in
  input  logic                  recv_val,
  output logic                  recv_rdy,
  input  logic [`FXP_WIDTH-1:0] sample,

  // product stream out
  output logic                  send_val,
  input  logic                  send_rdy,
  output logic [`FXP_WIDTH-1:0] result
);

  fxp_pkg::cfg_t cfg;
  logic          in_wait;
  logic          do_add;
  logic          do_carry;

  // ============================================================
  // gain and mode registers
  // ============================================================

  fxp_gain_regs u_regs (
    .clk       (clk),
    .reset     (reset),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg       (cfg)
  );

  // ============================================================
  // multiplier
  // ============================================================

  fxp_mult_ctrl u_ctrl (
    .clk      (clk),
    .reset    (reset),
    .recv_val (recv_val),
    .send_rdy (send_rdy),
    .recv_rdy (recv_rdy),
    .send_val (send_val),
    .in_wait  (in_wait),
    .do_add   (do_add),
    .do_carry (do_carry)
  );

  fxp_mult_dpath u_dpath (
    .clk      (clk),
    .reset    (reset),
    .in_wait  (in_wait),
    .do_add   (do_add),
    .do_carry (do_carry),
    .sample   (sample),
    .cfg      (cfg),
    .result   (result)
  );

endmodule

`default_nettype wire

/* tb/fxp_gain_stage_tb.sv */
`default_nettype none

`include "fxp_defines.svh"

module fxp_gain_stage_tb;

  logic                  clk;
  logic                  reset;
  logic                  cfg_wr;
  logic                  cfg_addr;
  fxp_pkg::cfg_wdata_u   cfg_wdata;
  logic                  recv_val;
  logic                  recv_rdy;
  logic [`FXP_WIDTH-1:0] sample;
  logic                  send_val;
  logic                  send_rdy;
  logic [`FXP_WIDTH-1:0] result;

  // model copy of the configuration registers
  logic [`FXP_WIDTH-1:0] model_gain;
  logic                  model_signed;

  fxp_gain_stage u_dut (
    .clk       (clk),
    .reset     (reset),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .recv_val  (recv_val),
    .recv_rdy  (recv_rdy),
    .sample    (sample),
    .send_val  (send_val),
    .send_rdy  (send_rdy),
    .result    (result)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ============================================================
  // reporting and reference model
  // ============================================================

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("test failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_value(input string name, input logic [`FXP_WIDTH-1:0] got,
                             input logic [`FXP_WIDTH-1:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Mismatch at time %0t: %s is %h, expected %h",
                              $time, name, got, exp));
    end
  endtask

  // full double-width product, floored by the arithmetic shift
  function automatic logic [`FXP_WIDTH-1:0] expected_product(
    input logic [`FXP_WIDTH-1:0] a,
    input logic [`FXP_WIDTH-1:0] g,
    input logic                  sgn
  );
    logic signed [2*`FXP_WIDTH-1:0] full;
    if (sgn) begin
      full = $signed({{`FXP_WIDTH{a[`FXP_WIDTH-1]}}, a}) *
             $signed({{`FXP_WIDTH{g[`FXP_WIDTH-1]}}, g});
    end else begin
      full = $signed({{`FXP_WIDTH{1'b0}}, a} * {{`FXP_WIDTH{1'b0}}, g});
    end
    full = full >>> `FXP_FRAC;
    return full[`FXP_WIDTH-1:0];
  endfunction

  // mostly random, some negative, most negative or small values
  function automatic logic [`FXP_WIDTH-1:0] random_operand();
    logic [`FXP_WIDTH-1:0] v;
    v = $urandom;
    case ($urandom % 8)
      0: v = {1'b1, {(`FXP_WIDTH-1){1'b0}}};
      1: v[`FXP_WIDTH-1] = 1'b1;
      2: v = v >> `FXP_FRAC;
      default: ;
    endcase
    return v;
  endfunction

  // ============================================================
  // bus tasks
  // ============================================================

  task automatic wait_until_idle();
    int n;
    n = 0;
    @(negedge clk);
    while (!recv_rdy) begin
      if (n == 100) begin
        stop_on_error("timeout waiting for recv_rdy to go high");
      end
      n++;
      @(negedge clk);
    end
  endtask

  task automatic write_gain(input logic [`FXP_WIDTH-1:0] g);
    @(posedge clk);
    cfg_wr         <= 1'b1;
    cfg_addr       <= `FXP_ADDR_GAIN;
    cfg_wdata.gain <= g;
    @(posedge clk);
    cfg_wr <= 1'b0;
    model_gain = g;
  endtask

  task automatic write_mode(input logic en);
    fxp_pkg::cfg_wdata_u w;
    // reserved bits are junk on purpose
    w.mode.reserved  = $urandom;
    w.mode.signed_en = en;
    @(posedge clk);
    cfg_wr    <= 1'b1;
    cfg_addr  <= `FXP_ADDR_MODE;
    cfg_wdata <= w;
    @(posedge clk);
    cfg_wr <= 1'b0;
    model_signed = en;
  endtask

  // one sample through, optional gain write while calculating
  task automatic run_op(input logic [`FXP_WIDTH-1:0] s, input logic mid_write,
                        input logic [`FXP_WIDTH-1:0] new_gain);
    logic [`FXP_WIDTH-1:0] exp;
    int lat;
    int hold;
    exp = expected_product(s, model_gain, model_signed);
    wait_until_idle();
    @(posedge clk);
    recv_val <= 1'b1;
    sample   <= s;
    // accepting edge
    @(posedge clk);
    recv_val <= 1'b0;
    sample   <= $urandom;
    lat = 0;
    @(negedge clk);
    while (!send_val) begin
      check_value("recv_rdy", recv_rdy, 1'b0);
      if (lat == 100) begin
        stop_on_error("timeout waiting for send_val to go high");
      end
      @(posedge clk);
      lat++;
      cfg_wr         <= mid_write && (lat == 4);
      cfg_addr       <= `FXP_ADDR_GAIN;
      cfg_wdata.gain <= new_gain;
      @(negedge clk);
    end
    if (mid_write) begin
      model_gain = new_gain;
    end
    // send_val rises FXP_WIDTH edges after the accepting edge
    check_value("latency", lat, `FXP_WIDTH);
    check_value("result", result, exp);
    hold = $urandom % 21;
    for (int i = 0; i < hold; i++) begin
      @(posedge clk);
      @(negedge clk);
      check_value("send_val", send_val, 1'b1);
      check_value("recv_rdy", recv_rdy, 1'b0);
      check_value("result", result, exp);
    end
    @(posedge clk);
    send_rdy <= 1'b1;
    @(posedge clk);
    send_rdy <= 1'b0;
    @(negedge clk);
    check_value("send_val", send_val, 1'b0);
    check_value("recv_rdy", recv_rdy, 1'b1);
  endtask

  task automatic mixed_op();
    if ($urandom % 2) begin
      write_gain(random_operand());
    end
    run_op(random_operand(), ($urandom % 8) == 0, random_operand());
  endtask

  // ============================================================
  // stimulus
  // ============================================================

  initial begin
    void'($urandom(32'h2590_d742));
    reset        = 1'b1;
    cfg_wr       = 1'b0;
    cfg_addr     = 1'b0;
    cfg_wdata    = '0;
    recv_val     = 1'b0;
    sample       = '0;
    send_rdy     = 1'b0;
    model_gain   = `FXP_GAIN_RESET;
    model_signed = 1'b1;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_value("recv_rdy", recv_rdy, 1'b1);
    check_value("send_val", send_val, 1'b0);
    // unity gain after reset, result equals sample
    for (int i = 0; i < 20; i++) begin
      run_op(random_operand(), 1'b0, '0);
    end
    write_mode(1'b0);
    for (int i = 0; i < 200; i++) begin
      mixed_op();
    end
    write_mode(1'b1);
    for (int i = 0; i < 200; i++) begin
      mixed_op();
    end
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

/* fxp_gain_stage.f */
+incdir+design
design/fxp_pkg.sv
design/fxp_gain_regs.sv
design/fxp_mult_ctrl.sv
design/fxp_mult_dpath.sv
design/fxp_gain_stage.sv
tb/fxp_gain_stage_tb.sv
